//--- project.f
logic/ExecPkg.sv
logic/ExecIf.sv
logic/MulDivUnit.sv
logic/CsrFile.sv
logic/ExecuteStage.sv
logic/ExecCore.sv
tests/ExecCoreTb.sv

//--- Bender.yml
package:
  name: exec_core

sources:
  - logic/ExecPkg.sv
  - logic/ExecIf.sv
  - logic/MulDivUnit.sv
  - logic/CsrFile.sv
  - logic/ExecuteStage.sv
  - logic/ExecCore.sv
  - target: test
    files:
      - tests/ExecCoreTb.sv

//--- tests/ExecCoreTb.sv
////////////////////////////////////////
// Testbench for the execute core. Runs
// ALU, branch, mul/div, bypass and CSR ops
////////////////////////////////////////
module ExecCoreTb import ExecPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int Xlen = 32;
    localparam int WaitLimit = 100;

    logic clk;
    logic rstN;
    logic inValid;
    ExecOp inOp;
    logic [Xlen-1:0] inPc;
    logic [Xlen-1:0] inImm;
    logic [4:0] inSrcAddr1;
    logic [4:0] inSrcAddr2;
    logic [4:0] inDstAddr;
    logic [Xlen-1:0] inSrcValue1;
    logic [Xlen-1:0] inSrcValue2;
    logic [11:0] inCsrAddr;
    logic stall;
    logic outValid;
    logic [4:0] outDst;
    logic [Xlen-1:0] outResult;
    logic outBranchTaken;
    logic [Xlen-1:0] outNextPc;
    logic outTrap;
    TrapCause outTrapCause;

    // reference model state
    logic mPrevWrote;
    logic [4:0] mPrevDst;
    logic [31:0] mPrevResult;
    logic [31:0] mScratch;
    logic [31:0] mTvec;
    logic [31:0] mInstret;
    logic mOutValid;
    logic [31:0] rngState = 32'd69;
    logic [31:0] value;
    int errors = 0;
    int checks = 0;

    ExecCore #(.Xlen(Xlen)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assert property (@(posedge clk) disable iff (!rstN) stall |=> !outValid)
        else begin
            errors++;
            $display("an output was valid right after a stall cycle");
        end
    assert property (@(posedge clk) disable iff (!rstN) outTrap |-> outValid)
        else begin
            errors++;
            $display("outTrap was raised without outValid");
        end

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [4:0] randAddr();
        logic [31:0] r;
        r = nextRandom();
        return r[4:0];
    endfunction

    function automatic ExecOp makeOp(ExUnitType unit, AluCommand cmd, BranchType kind,
                                     MulDivCommand md, AluSrcType1 src1, AluSrcType2 src2,
                                     logic wrd, logic wcsr);
        return '{unit, cmd, kind, md, src1, src2, wrd, wcsr};
    endfunction

    function automatic ExecOp aluRegOp(AluCommand cmd);
        return makeOp(UnitAlu, cmd, BranchEqual, MulDivMul, Src1Reg, Src2Reg, 1'b1, 1'b0);
    endfunction

    function automatic ExecOp csrOp(AluCommand cmd, AluSrcType1 src1, AluSrcType2 src2,
                                    logic wcsr);
        return makeOp(UnitCsr, cmd, BranchEqual, MulDivMul, src1, src2, 1'b1, wcsr);
    endfunction

    function automatic logic [31:0] expectAlu(AluCommand cmd, logic [31:0] a, logic [31:0] b);
        case (cmd)
            AluAdd: return a + b;
            AluSub: return a - b;
            AluSll: return a << b[4:0];
            AluSlt: return {31'b0, $signed(a) < $signed(b)};
            AluSltu: return {31'b0, a < b};
            AluXor: return a ^ b;
            AluSrl: return a >> b[4:0];
            AluSra: return $unsigned($signed(a) >>> b[4:0]);
            AluOr: return a | b;
            AluAnd: return a & b;
            AluClear1: return a & ~b;
            AluClear2: return ~a & b;
            default: return '0;
        endcase
    endfunction

    function automatic logic expectBranch(BranchType kind, logic [31:0] a, logic [31:0] b);
        case (kind)
            BranchEqual: return a == b;
            BranchNotEqual: return a != b;
            BranchLessThan: return $signed(a) < $signed(b);
            BranchGreaterEqual: return !($signed(a) < $signed(b));
            BranchUnsignedLessThan: return a < b;
            BranchUnsignedGreaterEqual: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] expectMulDiv(MulDivCommand cmd, logic [31:0] a,
                                                 logic [31:0] b);
        logic [63:0] product;
        product = {32'b0, a} * {32'b0, b};
        case (cmd)
            MulDivMul: return product[31:0];
            MulDivMulHu: return product[63:32];
            MulDivDivu: return (b == 0) ? 32'hFFFF_FFFF : a / b;
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [31:0] bypass(logic [4:0] addr, logic [31:0] supplied);
        return (addr != 0 && mPrevWrote && addr == mPrevDst) ? mPrevResult : supplied;
    endfunction

    function automatic logic [31:0] csrModelRead(logic [11:0] addr);
        case (addr)
            CsrScratch: return mScratch;
            CsrTvec: return mTvec;
            CsrInstret: return mInstret;
            default: return '0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic finishRun();
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // model side of one clock edge for the retire count and bypass validity
    task automatic retireEdge(input logic accepted, input logic instretWritten);
        if (mOutValid && !instretWritten) begin
            mInstret++;
        end
        mOutValid = accepted;
        if (!accepted) begin
            mPrevWrote = 1'b0;
        end
    endtask

    task automatic idleCycle();
        inValid = 1'b0;
        @(negedge clk);
        checkValue("outValid", outValid, 0);
        retireEdge(1'b0, 1'b0);
    endtask

    // starts on a falling edge and ends on the one that shows the result
    task automatic execOp(input ExecOp op, input logic [4:0] a1, input logic [4:0] a2,
                          input logic [4:0] dst, input logic [31:0] v1, input logic [31:0] v2,
                          input logic [31:0] imm, input logic [11:0] csrAddr);
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] pc;
        logic [31:0] old;
        logic [31:0] aluOut;
        logic [31:0] expResult;
        logic illegal;
        logic taken;
        logic csrWrite;
        logic stallDropped;
        int cycles;
        s1 = bypass(a1, v1);
        s2 = bypass(a2, v2);
        pc = nextRandom() & 32'hFFFF_FFFC;
        illegal = op.unitType == UnitCsr
                  && !(csrAddr inside {CsrScratch, CsrTvec, CsrInstret});
        old = csrModelRead(csrAddr);
        case (op.aluSrc1)
            Src1Pc: x1 = pc;
            Src1Reg: x1 = s1;
            Src1Csr: x1 = old;
            default: x1 = '0;
        endcase
        case (op.aluSrc2)
            Src2Imm: x2 = imm;
            Src2Reg: x2 = s2;
            Src2Csr: x2 = old;
            default: x2 = '0;
        endcase
        aluOut = expectAlu(op.aluCommand, x1, x2);
        taken = op.unitType == UnitBranch && expectBranch(op.branchType, s1, s2);
        case (op.unitType)
            UnitAlu: expResult = aluOut;
            UnitBranch: expResult = pc + 4;
            UnitMulDiv: expResult = expectMulDiv(op.mulDivCommand, s1, s2);
            default: expResult = old;
        endcase
        csrWrite = op.unitType == UnitCsr && op.writesCsr && !illegal;

        inValid = 1'b1;
        inOp = op;
        inPc = pc;
        inImm = imm;
        inSrcAddr1 = a1;
        inSrcAddr2 = a2;
        inDstAddr = dst;
        inSrcValue1 = v1;
        inSrcValue2 = v2;
        inCsrAddr = csrAddr;
        #1;
        checkValue("stall", stall, op.unitType == UnitMulDiv);

        cycles = 0;
        stallDropped = 1'b0;
        forever begin
            @(negedge clk);
            cycles++;
            if (outValid) break;
            expectTrue(op.unitType == UnitMulDiv, "no result one cycle after accepting the op");
            if (!stall) begin
                expectTrue(!stallDropped, "stall fell while the mul/div op was still running");
                stallDropped = 1'b1;
            end
            retireEdge(1'b0, 1'b0);
            if (cycles > WaitLimit) begin
                errors++;
                $display("timed out waiting for outValid");
                finishRun();
            end
        end
        retireEdge(1'b1, csrWrite && csrAddr == CsrInstret);

        checkValue("outResult", outResult, expResult);
        checkValue("outDst", outDst, dst);
        checkValue("outTrap", outTrap, illegal);
        checkValue("outTrapCause", outTrapCause, illegal ? TrapIllegalInsn : TrapNone);
        checkValue("outBranchTaken", outBranchTaken, taken);
        checkValue("outNextPc", outNextPc, taken ? pc + imm : pc + 4);

        mPrevWrote = op.writesRd && !illegal;
        mPrevDst = dst;
        mPrevResult = expResult;
        if (csrWrite) begin
            case (csrAddr)
                CsrScratch: mScratch = aluOut;
                CsrTvec: mTvec = aluOut & 32'hFFFF_FFFC;
                default: mInstret = aluOut;
            endcase
        end
    endtask

    initial begin
        rstN = 1'b0;
        inValid = 1'b0;
        inOp = '0;
        inPc = '0;
        inImm = '0;
        inSrcAddr1 = '0;
        inSrcAddr2 = '0;
        inDstAddr = '0;
        inSrcValue1 = '0;
        inSrcValue2 = '0;
        inCsrAddr = '0;
        mPrevWrote = 1'b0;
        mPrevDst = '0;
        mPrevResult = '0;
        mScratch = '0;
        mTvec = '0;
        mInstret = '0;
        mOutValid = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkValue("outValid", outValid, 0);
        checkValue("outTrap", outTrap, 0);
        checkValue("stall", stall, 0);

        // every ALU command in register and immediate form
        for (int i = 0; i < 12; i++) begin
            execOp(aluRegOp(AluCommand'(i)), randAddr(), randAddr(), randAddr(),
                   nextRandom(), nextRandom(), nextRandom(), CsrScratch);
            execOp(makeOp(UnitAlu, AluCommand'(i), BranchEqual, MulDivMul, Src1Reg, Src2Imm,
                          1'b1, 1'b0), randAddr(), randAddr(), randAddr(),
                   nextRandom(), nextRandom(), nextRandom(), CsrScratch);
            idleCycle();
        end

        // branches on random and equal pairs
        for (int i = 0; i < 7; i++) begin
            value = nextRandom();
            execOp(makeOp(UnitBranch, AluAdd, BranchType'(i), MulDivMul, Src1Pc, Src2Imm,
                          1'b0, 1'b0), randAddr(), randAddr(), 5'd0,
                   value, nextRandom(), nextRandom(), CsrScratch);
            execOp(makeOp(UnitBranch, AluAdd, BranchType'(i), MulDivMul, Src1Pc, Src2Imm,
                          1'b0, 1'b0), randAddr(), randAddr(), 5'd0,
                   value, value, nextRandom(), CsrScratch);
        end

        // mul/div on random operands and on a zero divisor from x0
        for (int i = 0; i < 4; i++) begin
            execOp(makeOp(UnitMulDiv, AluAdd, BranchEqual, MulDivCommand'(i), Src1Reg,
                          Src2Reg, 1'b1, 1'b0), randAddr(), randAddr(), randAddr(),
                   nextRandom(), nextRandom(), 0, CsrScratch);
            execOp(makeOp(UnitMulDiv, AluAdd, BranchEqual, MulDivCommand'(i), Src1Reg,
                          Src2Reg, 1'b1, 1'b0), randAddr(), 5'd0, randAddr(),
                   nextRandom(), 0, 0, CsrScratch);
        end

        // dependent chain where x0 is never forwarded
        idleCycle();
        execOp(aluRegOp(AluAdd), 5'd3, 5'd4, 5'd7, nextRandom(), nextRandom(), 0, CsrScratch);
        execOp(aluRegOp(AluXor), 5'd7, 5'd7, 5'd9, nextRandom(), nextRandom(), 0, CsrScratch);
        execOp(aluRegOp(AluSub), 5'd9, 5'd2, 5'd0, nextRandom(), nextRandom(), 0, CsrScratch);
        execOp(aluRegOp(AluOr), 5'd0, 5'd0, 5'd1, nextRandom(), nextRandom(), 0, CsrScratch);
        execOp(makeOp(UnitMulDiv, AluAdd, BranchEqual, MulDivMul, Src1Reg, Src2Reg, 1'b1,
                      1'b0), 5'd1, 5'd6, 5'd8, nextRandom(), nextRandom(), 0, CsrScratch);
        execOp(aluRegOp(AluAdd), 5'd8, 5'd1, 5'd2, nextRandom(), nextRandom(), 0, CsrScratch);

        // write, set, clear and read back on scratch and tvec
        for (int i = 0; i < 2; i++) begin
            inCsrAddr = (i == 0) ? CsrScratch : CsrTvec;
            execOp(csrOp(AluAdd, Src1Zero, Src2Reg, 1'b1), 5'd0, randAddr(), randAddr(),
                   0, nextRandom(), 0, inCsrAddr);
            execOp(csrOp(AluOr, Src1Csr, Src2Reg, 1'b1), 5'd0, randAddr(), randAddr(),
                   0, nextRandom(), 0, inCsrAddr);
            execOp(csrOp(AluClear1, Src1Csr, Src2Reg, 1'b1), 5'd0, randAddr(), randAddr(),
                   0, nextRandom(), 0, inCsrAddr);
            execOp(csrOp(AluOr, Src1Csr, Src2Zero, 1'b0), 5'd0, 5'd0, randAddr(),
                   0, 0, 0, inCsrAddr);
        end

        // instret since reset and since a write
        execOp(csrOp(AluOr, Src1Csr, Src2Zero, 1'b0), 5'd0, 5'd0, 5'd5, 0, 0, 0, CsrInstret);
        execOp(csrOp(AluAdd, Src1Zero, Src2Reg, 1'b1), 5'd0, 5'd0, 5'd5, 0, 32'h40, 0,
               CsrInstret);
        idleCycle();
        execOp(aluRegOp(AluAnd), randAddr(), randAddr(), 5'd4, nextRandom(), nextRandom(), 0,
               CsrScratch);
        idleCycle();
        execOp(csrOp(AluOr, Src1Csr, Src2Zero, 1'b0), 5'd0, 5'd0, 5'd5, 0, 0, 0, CsrInstret);

        // unknown CSR traps and leaves state and forwarding alone
        execOp(csrOp(AluAdd, Src1Zero, Src2Reg, 1'b1), 5'd0, 5'd11, 5'd12, 0, nextRandom(), 0,
               12'h7C0);
        execOp(aluRegOp(AluAdd), 5'd12, 5'd12, 5'd13, nextRandom(), nextRandom(), 0, CsrScratch);
        execOp(csrOp(AluOr, Src1Csr, Src2Zero, 1'b0), 5'd0, 5'd0, 5'd14, 0, 0, 0, CsrScratch);
        idleCycle();

        finishRun();
    end

endmodule

//--- logic/ExecCore.sv
////////////////////////////////////////
// Execute core top: stage, mul/div unit
// and CSR block behind plain ports
////////////////////////////////////////
module ExecCore import ExecPkg::*; #(
    parameter int Xlen = 32
) (
    input logic clk,
    input logic rstN,
    input logic inValid,
    input ExecOp inOp,
    input logic [Xlen-1:0] inPc,
    input logic [Xlen-1:0] inImm,
    input logic [4:0] inSrcAddr1,
    input logic [4:0] inSrcAddr2,
    input logic [4:0] inDstAddr,
    input logic [Xlen-1:0] inSrcValue1,
    input logic [Xlen-1:0] inSrcValue2,
    input logic [11:0] inCsrAddr,
    output logic stall,
    output logic outValid,
    output logic [4:0] outDst,
    output logic [Xlen-1:0] outResult,
    output logic outBranchTaken,
    output logic [Xlen-1:0] outNextPc,
    output logic outTrap,
    output TrapCause outTrapCause
);
    MulDivIf #(.Xlen(Xlen)) mulDivBus ();
    CsrIf #(.Xlen(Xlen)) csrBus ();

    ExecuteStage #(.Xlen(Xlen)) stage (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inOp(inOp),
        .inPc(inPc),
        .inImm(inImm),
        .inSrcAddr1(inSrcAddr1),
        .inSrcAddr2(inSrcAddr2),
        .inDstAddr(inDstAddr),
        .inSrcValue1(inSrcValue1),
        .inSrcValue2(inSrcValue2),
        .inCsrAddr(inCsrAddr),
        .mulDiv(mulDivBus.Requester),
        .csr(csrBus.Stage),
        .stall(stall),
        .outValid(outValid),
        .outBranchTaken(outBranchTaken),
        .outTrap(outTrap),
        .outDst(outDst),
        .outResult(outResult),
        .outNextPc(outNextPc),
        .outTrapCause(outTrapCause)
    );

    MulDivUnit #(.Xlen(Xlen)) mulDivUnit (
        .clk(clk),
        .rstN(rstN),
        .unit(mulDivBus.Unit)
    );

    // every op leaving the stage counts as retired
    CsrFile #(.Xlen(Xlen)) csrFile (
        .clk(clk),
        .rstN(rstN),
        .retire(outValid),
        .csr(csrBus.File)
    );

endmodule

//--- logic/ExecuteStage.sv
////////////////////////////////////////
// Integer execute stage: bypass, ALU,
// branch, CSR access and EX/MEM register
////////////////////////////////////////
module ExecuteStage import ExecPkg::*; #(
    parameter int Xlen = 32
) (
    input logic clk,
    input logic rstN,
    input logic inValid,
    input ExecOp inOp,
    input logic [Xlen-1:0] inPc,
    input logic [Xlen-1:0] inImm,
    input logic [4:0] inSrcAddr1,
    input logic [4:0] inSrcAddr2,
    input logic [4:0] inDstAddr,
    input logic [Xlen-1:0] inSrcValue1,
    input logic [Xlen-1:0] inSrcValue2,
    input logic [11:0] inCsrAddr,
    MulDivIf.Requester mulDiv,
    CsrIf.Stage csr,
    output logic stall,
    output logic outValid,
    output logic outBranchTaken,
    output logic outTrap,
    output logic [4:0] outDst,
    output logic [Xlen-1:0] outResult,
    output logic [Xlen-1:0] outNextPc,
    output TrapCause outTrapCause
);
    localparam int ShiftWidth = $clog2(Xlen);

    function automatic logic [Xlen-1:0] alu(AluCommand command, logic [Xlen-1:0] a,
                                             logic [Xlen-1:0] b);
        logic [ShiftWidth-1:0] shamt;
        shamt = b[ShiftWidth-1:0];
        unique case (command)
            AluAdd: return a + b;
            AluSub: return a - b;
            AluSll: return a << shamt;
            AluSlt: return Xlen'($signed(a) < $signed(b));
            AluSltu: return Xlen'(a < b);
            AluXor: return a ^ b;
            AluSrl: return a >> shamt;
            AluSra: return Xlen'($signed(a) >>> shamt);
            AluOr: return a | b;
            AluAnd: return a & b;
            AluClear1: return a & ~b;
            AluClear2: return ~a & b;
            default: return '0;
        endcase
    endfunction

    function automatic logic branchCompare(BranchType kind, logic [Xlen-1:0] a,
                                           logic [Xlen-1:0] b);
        unique case (kind)
            BranchEqual: return a == b;
            BranchNotEqual: return a != b;
            BranchLessThan: return $signed(a) < $signed(b);
            BranchGreaterEqual: return $signed(a) >= $signed(b);
            BranchUnsignedLessThan: return a < b;
            BranchUnsignedGreaterEqual: return a >= b;
            BranchAlways: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // registered op left a value in outResult for forwarding
    logic wroteRd;
    logic [Xlen-1:0] srcValue1;
    logic [Xlen-1:0] srcValue2;
    logic [Xlen-1:0] aluSrc1;
    logic [Xlen-1:0] aluSrc2;
    logic [Xlen-1:0] aluResult;
    logic [Xlen-1:0] pcPlus4;
    logic [Xlen-1:0] result;
    logic branchTaken;
    logic trap;
    logic accept;

    always_comb begin
        srcValue1 = (wroteRd && inSrcAddr1 == outDst && inSrcAddr1 != 5'd0) ? outResult
                                                                              : inSrcValue1;
        srcValue2 = (wroteRd && inSrcAddr2 == outDst && inSrcAddr2 != 5'd0) ? outResult
                                                                              : inSrcValue2;

        unique case (inOp.aluSrc1)
            Src1Pc: aluSrc1 = inPc;
            Src1Reg: aluSrc1 = srcValue1;
            Src1Csr: aluSrc1 = csr.readValue;
            default: aluSrc1 = '0;
        endcase
        unique case (inOp.aluSrc2)
            Src2Imm: aluSrc2 = inImm;
            Src2Reg: aluSrc2 = srcValue2;
            Src2Csr: aluSrc2 = csr.readValue;
            default: aluSrc2 = '0;
        endcase

        aluResult = alu(inOp.aluCommand, aluSrc1, aluSrc2);
        pcPlus4 = inPc + Xlen'(4);
        branchTaken = (inOp.unitType == UnitBranch)
                      && branchCompare(inOp.branchType, srcValue1, srcValue2);

        // csr ops hand back the old value, the ALU output is the new one
        unique case (inOp.unitType)
            UnitBranch: result = pcPlus4;
            UnitMulDiv: result = mulDiv.result;
            UnitCsr: result = csr.readValue;
            default: result = aluResult;
        endcase

        trap = inValid && inOp.unitType == UnitCsr && csr.readIllegal;
        stall = inValid && inOp.unitType == UnitMulDiv && !mulDiv.done;
        accept = inValid && !stall;
    end

    assign mulDiv.enable = inValid && inOp.unitType == UnitMulDiv;
    assign mulDiv.command = inOp.mulDivCommand;
    assign mulDiv.src1 = srcValue1;
    assign mulDiv.src2 = srcValue2;

    assign csr.readAddr = inCsrAddr;
    assign csr.writeEnable = accept && !trap && inOp.writesCsr;
    assign csr.writeValue = aluResult;

    // bubble while stalled
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            outTrap <= 1'b0;
            wroteRd <= 1'b0;
        end else begin
            outValid <= accept;
            outTrap <= accept && trap;
            wroteRd <= accept && !trap && inOp.writesRd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            outDst <= inDstAddr;
            outResult <= result;
            outBranchTaken <= branchTaken;
            // taken target comes from the ALU add of pc and imm
            outNextPc <= branchTaken ? aluResult : pcPlus4;
            outTrapCause <= trap ? TrapIllegalInsn : TrapNone;
        end
    end

endmodule

//--- logic/CsrFile.sv
////////////////////////////////////////
// Small CSR block next to the execute
// stage: scratch, trap vector, instret
////////////////////////////////////////
module CsrFile import ExecPkg::*; #(
    parameter int Xlen = 32
) (
    input logic clk,
    input logic rstN,
    input logic retire,
    CsrIf.File csr
);
    logic [Xlen-1:0] scratch;
    logic [Xlen-1:0] tvec;
    logic [Xlen-1:0] instret;

    always_comb begin
        csr.readIllegal = 1'b0;
        unique case (csr.readAddr)
            CsrScratch: csr.readValue = scratch;
            CsrTvec: csr.readValue = tvec;
            CsrInstret: csr.readValue = instret;
            default: begin
                csr.readValue = '0;
                csr.readIllegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            scratch <= '0;
            tvec <= '0;
            instret <= '0;
        end else begin
            if (csr.writeEnable && csr.readAddr == CsrScratch) begin
                scratch <= csr.writeValue;
            end
            // vector base is word aligned
            if (csr.writeEnable && csr.readAddr == CsrTvec) begin
                tvec <= {csr.writeValue[Xlen-1:2], 2'b00};
            end
            // a write wins over the retire count
            if (csr.writeEnable && csr.readAddr == CsrInstret) begin
                instret <= csr.writeValue;
            end else if (retire) begin
                instret <= instret + Xlen'(1);
            end
        end
    end

endmodule

//--- logic/MulDivUnit.sv
////////////////////////////////////////
// Iterative unsigned multiply and divide,
// one bit per cycle, done pulses at end
////////////////////////////////////////
module MulDivUnit import ExecPkg::*; #(
    parameter int Xlen = 32
) (
    input logic clk,
    input logic rstN,
    MulDivIf.Unit unit
);
    localparam int CountWidth = $clog2(Xlen);

    typedef enum logic [1:0] {StateIdle, StateBusy, StateDone} MulDivState;

    MulDivState state;
    logic [CountWidth-1:0] count;
    MulDivCommand command;
    // multiplicand or divisor
    logic [Xlen-1:0] operand;
    // mul: {partial product, multiplier}, div: {remainder, quotient}
    logic [2*Xlen-1:0] acc;
    logic isDivide;
    logic [Xlen:0] mulSum;
    logic [Xlen:0] divShifted;
    logic [Xlen:0] divDiff;

    always_comb begin
        isDivide = command inside {MulDivDivu, MulDivRemu};
        mulSum = {1'b0, acc[2*Xlen-1:Xlen]} + (acc[0] ? {1'b0, operand} : '0);
        divShifted = acc[2*Xlen-1:Xlen-1];
        divDiff = divShifted - {1'b0, operand};
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= StateIdle;
        end else begin
            unique case (state)
                StateIdle: if (unit.enable) state <= StateBusy;
                StateBusy: if (count == CountWidth'(Xlen - 1)) state <= StateDone;
                default: state <= StateIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateIdle && unit.enable) begin
            command <= unit.command;
            count <= '0;
            // product is symmetric, so src1 always goes into the low half
            operand <= unit.src2;
            acc <= {{Xlen{1'b0}}, unit.src1};
        end else if (state == StateBusy) begin
            count <= count + CountWidth'(1);
            if (!isDivide) begin
                acc <= {mulSum, acc[Xlen-1:1]};
            end else if (divDiff[Xlen]) begin
                // restore, quotient bit 0
                acc <= {divShifted[Xlen-1:0], acc[Xlen-2:0], 1'b0};
            end else begin
                acc <= {divDiff[Xlen-1:0], acc[Xlen-2:0], 1'b1};
            end
        end
    end

    // zero divisor falls out as all-ones quotient, remainder = dividend
    assign unit.done = (state == StateDone);
    assign unit.result = (command inside {MulDivMul, MulDivDivu}) ? acc[Xlen-1:0]
                                                                   : acc[2*Xlen-1:Xlen];

endmodule

//--- logic/ExecIf.sv
////////////////////////////////////////
// Bundles between the execute stage and
// its mul/div unit and CSR block
////////////////////////////////////////
interface MulDivIf import ExecPkg::*; #(
    parameter int Xlen = 32
) ();
    // enable is held for as long as the op sits in the stage
    logic enable;
    MulDivCommand command;
    logic [Xlen-1:0] src1;
    logic [Xlen-1:0] src2;
    logic done;
    logic [Xlen-1:0] result;

    modport Requester (output enable, command, src1, src2, input done, result);
    modport Unit (input enable, command, src1, src2, output done, result);
endinterface

interface CsrIf #(
    parameter int Xlen = 32
) ();
    // readAddr doubles as the write address
    logic [11:0] readAddr;
    logic [Xlen-1:0] readValue;
    logic readIllegal;
    logic writeEnable;
    logic [Xlen-1:0] writeValue;

    modport Stage (output readAddr, writeEnable, writeValue, input readValue, readIllegal);
    modport File (input readAddr, writeEnable, writeValue, output readValue, readIllegal);
endinterface

//--- logic/ExecPkg.sv
////////////////////////////////////////
// Shared types for the execute stage:
// op encodings, decoded op, CSR addresses
////////////////////////////////////////
package ExecPkg;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluClear1,
        AluClear2
    } AluCommand;

    typedef enum logic [2:0] {
        BranchEqual,
        BranchNotEqual,
        BranchLessThan,
        BranchGreaterEqual,
        BranchUnsignedLessThan,
        BranchUnsignedGreaterEqual,
        BranchAlways
    } BranchType;

    // unsigned variants only
    typedef enum logic [1:0] {MulDivMul, MulDivMulHu, MulDivDivu, MulDivRemu} MulDivCommand;

    typedef enum logic [1:0] {UnitAlu, UnitBranch, UnitMulDiv, UnitCsr} ExUnitType;

    typedef enum logic [1:0] {Src1Zero, Src1Pc, Src1Reg, Src1Csr} AluSrcType1;

    typedef enum logic [1:0] {Src2Zero, Src2Imm, Src2Reg, Src2Csr} AluSrcType2;

    // encoding follows the RISC-V exception codes
    typedef enum logic [3:0] {
        TrapNone = 4'd0,
        TrapIllegalInsn = 4'd2
    } TrapCause;

    typedef struct packed {
        ExUnitType unitType;
        AluCommand aluCommand;
        BranchType branchType;
        MulDivCommand mulDivCommand;
        AluSrcType1 aluSrc1;
        AluSrcType2 aluSrc2;
        logic writesRd;
        logic writesCsr;
    } ExecOp;

    localparam logic [11:0] CsrScratch = 12'h340;
    localparam logic [11:0] CsrTvec = 12'h305;
    localparam logic [11:0] CsrInstret = 12'hB02;

endpackage
